// ==== hw/dmmu_pkg.sv ====
// Data MMU package with widths, page split and the TLB, status and command types
package dmmu_pkg;

   // Data and address width
   localparam int dw = 32;

   // Page offset bits, 8 KB pages
   localparam int page_shift = 13;

   // Virtual and physical page number widths
   localparam int vpn_w = dw - page_shift;
   localparam int ppn_w = dw - page_shift;

   // Low TLB word
   // VPN on top, valid flag at bit 0
   typedef struct packed {
      logic [vpn_w-1:0] vpn;
      logic [11:0]      rsv;
      logic             v;
   } tlb_lo_t;

   // High TLB word
   // PPN on top, permission and attribute bits below, present at bit 0
   typedef struct packed {
      logic [ppn_w-1:0] ppn;
      logic [3:0]       rsv_hi;
      // Shared page, stored only
      logic             s;
      // Non-cacheable page, stored only
      logic             nc;
      // Root read and write
      logic             rr;
      logic             rw;
      // User read and write
      logic             ur;
      logic             uw;
      logic [1:0]       rsv_lo;
      logic             p;
   } tlb_hi_t;

   // Processor status bits seen by the data MMU
   typedef struct packed {
      // Translation enable
      logic dmme;
      // Root mode
      logic rm;
   } psr_t;

   // One word access
   // Same layout for virtual and physical commands
   typedef struct packed {
      logic [dw-1:0] addr;
      logic          we;
      logic [dw-1:0] wdata;
   } mem_cmd_t;

endpackage

// ==== hw/cmd_pipebuf.sv ====
// One-entry valid/ready buffer with bypassed ready and a cancel input
module cmd_pipebuf (
   input  logic clk,
   input  logic reset,
   input  logic in_valid,
   output logic in_ready,
   output logic out_valid,
   input  logic out_ready,
   input  logic cancel,
   output logic accept
);

   // Occupancy of the single slot
   logic full;

   // Slot frees up in the same cycle
   // when its entry leaves or gets cancelled
   assign in_ready = ~full | out_ready | cancel;

   // Input side transfer
   assign accept = in_valid & in_ready;

   // Payload lives in the user of this buffer
   assign out_valid = full;

   always_ff @(posedge clk) begin
      if (reset) begin
         full <= 1'b0;
      end else if (accept) begin
         // New entry replaces one leaving now
         full <= 1'b1;
      end else if (out_ready | cancel) begin
         // Drain or discard
         full <= 1'b0;
      end
   end

endmodule

// ==== hw/tlb_ram.sv ====
// Dual-port synchronous TLB memory, read port A and software port B
module tlb_ram #(
   parameter int  AW = 7,
   parameter type entry_t = logic [31:0]
) (
   input  logic          clk,
   input  logic [AW-1:0] addr_a,
   input  logic          re_a,
   output entry_t        dout_a,
   input  logic [AW-1:0] addr_b,
   input  logic          we_b,
   input  entry_t        din_b,
   output entry_t        dout_b
);

   // 2^AW entries
   entry_t mem [2**AW];

   // Lookup port
   // Output holds while re_a is low
   // Same-edge write on port B is not seen here until the next read
   always_ff @(posedge clk) begin
      if (re_a) begin
         dout_a <= mem[addr_a];
      end
   end

   // Software port
   // Write-first, a write returns the new word on dout_b
   always_ff @(posedge clk) begin
      if (we_b) begin
         mem[addr_b] <= din_b;
         dout_b      <= din_b;
      end else begin
         dout_b <= mem[addr_b];
      end
   end

endmodule

// ==== hw/dmmu.sv ====
// Data MMU with command buffer, direct-mapped TLB lookup and permission checks
module dmmu #(
   parameter int TLB_NSETS_LOG2 = 7
) (
   input  logic                      clk,
   input  logic                      reset,
   // Command from the load/store unit
   input  logic                      cmd_valid,
   output logic                      cmd_ready,
   input  dmmu_pkg::mem_cmd_t        cmd,
   input  dmmu_pkg::psr_t            psr,
   // Translated command to memory
   output logic                      mem_cmd_valid,
   input  logic                      mem_cmd_ready,
   output dmmu_pkg::mem_cmd_t        mem_cmd,
   // Exception strobes
   output logic                      tlb_miss,
   output logic                      page_fault,
   output logic [dmmu_pkg::dw-1:0]   dmmid,
   // TLB software ports
   input  logic [TLB_NSETS_LOG2-1:0] tlbl_idx,
   input  dmmu_pkg::tlb_lo_t         tlbl_wdata,
   input  logic                      tlbl_we,
   output dmmu_pkg::tlb_lo_t         tlbl_rdata,
   input  logic [TLB_NSETS_LOG2-1:0] tlbh_idx,
   input  dmmu_pkg::tlb_hi_t         tlbh_wdata,
   input  logic                      tlbh_we,
   output dmmu_pkg::tlb_hi_t         tlbh_rdata
);

   // TLB_NSETS_LOG2 must not exceed vpn_w
   localparam logic [2:0] nsets_code = 3'(TLB_NSETS_LOG2);

   logic                        accept;
   logic                        buf_valid;
   logic                        cancel;
   logic [dmmu_pkg::vpn_w-1:0]  vpn_in;
   logic [TLB_NSETS_LOG2-1:0]   tlb_idx;
   dmmu_pkg::mem_cmd_t          cmd_r;
   dmmu_pkg::psr_t              psr_r;
   logic [dmmu_pkg::vpn_w-1:0]  vpn_r;
   dmmu_pkg::tlb_lo_t           tlb_lo;
   dmmu_pkg::tlb_hi_t           tlb_hi;
   logic                        tlb_hit;
   logic                        perm_ok;

   // Set count for software discovery
   assign dmmid = {{(dmmu_pkg::dw-3){1'b0}}, nsets_code};

   // Occupancy and handshake
   // Exceptions drop the buffered command
   cmd_pipebuf cmd_buf (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (cmd_valid),
      .in_ready  (cmd_ready),
      .out_valid (buf_valid),
      .out_ready (mem_cmd_ready),
      .cancel    (cancel),
      .accept    (accept)
   );

   // Direct-mapped index from the low VPN bits
   assign vpn_in  = cmd.addr[dmmu_pkg::dw-1:dmmu_pkg::page_shift];
   assign tlb_idx = vpn_in[TLB_NSETS_LOG2-1:0];

   // Command and status captured with the TLB read
   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_r <= cmd;
         psr_r <= psr;
      end
   end

   assign vpn_r = cmd_r.addr[dmmu_pkg::dw-1:dmmu_pkg::page_shift];

   // Low half, VPN tag and valid
   tlb_ram #(
      .AW      (TLB_NSETS_LOG2),
      .entry_t (dmmu_pkg::tlb_lo_t)
   ) tlb_lo_ram (
      .clk    (clk),
      .addr_a (tlb_idx),
      .re_a   (accept),
      .dout_a (tlb_lo),
      .addr_b (tlbl_idx),
      .we_b   (tlbl_we),
      .din_b  (tlbl_wdata),
      .dout_b (tlbl_rdata)
   );

   // High half, PPN and permissions
   tlb_ram #(
      .AW      (TLB_NSETS_LOG2),
      .entry_t (dmmu_pkg::tlb_hi_t)
   ) tlb_hi_ram (
      .clk    (clk),
      .addr_a (tlb_idx),
      .re_a   (accept),
      .dout_a (tlb_hi),
      .addr_b (tlbh_idx),
      .we_b   (tlbh_we),
      .din_b  (tlbh_wdata),
      .dout_b (tlbh_rdata)
   );

   // Tag compare
   assign tlb_hit = tlb_lo.v && (tlb_lo.vpn == vpn_r);

   // Root pair in root mode, user pair otherwise
   always_comb begin
      if (psr_r.rm) begin
         perm_ok = cmd_r.we ? tlb_hi.rw : tlb_hi.rr;
      end else begin
         perm_ok = cmd_r.we ? tlb_hi.uw : tlb_hi.ur;
      end
   end

   // Strobes only with a buffered command and translation on
   assign tlb_miss   = buf_valid & psr_r.dmme & ~tlb_hit;
   assign page_fault = buf_valid & psr_r.dmme & tlb_hit & ~perm_ok;
   assign cancel     = tlb_miss | page_fault;

   // Hide the command from memory in the exception cycle
   assign mem_cmd_valid = buf_valid & ~cancel;

   // PPN joined with page offset, or untouched address
   always_comb begin
      mem_cmd = cmd_r;
      if (psr_r.dmme) begin
         mem_cmd.addr = {tlb_hi.ppn, cmd_r.addr[dmmu_pkg::page_shift-1:0]};
      end
   end

endmodule

// ==== hw/data_ram.sv ====
// Word-wide data memory answering each command with one held response
module data_ram #(
   parameter int MEM_AW = 10
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    mem_cmd_valid,
   output logic                    mem_cmd_ready,
   input  dmmu_pkg::mem_cmd_t      mem_cmd,
   output logic                    rsp_valid,
   input  logic                    rsp_ready,
   output logic [dmmu_pkg::dw-1:0] rsp_data
);

   logic [dmmu_pkg::dw-1:0] mem [2**MEM_AW];
   logic [MEM_AW-1:0]       word_idx;
   logic                    cmd_xfer;

   // Byte address down to word index
   assign word_idx = mem_cmd.addr[MEM_AW+1:2];

   // Room for a new response
   // when none is held or the held one goes now
   assign mem_cmd_ready = ~rsp_valid | rsp_ready;
   assign cmd_xfer      = mem_cmd_valid & mem_cmd_ready;

   // Array write and response data
   always_ff @(posedge clk) begin
      if (cmd_xfer) begin
         if (mem_cmd.we) begin
            mem[word_idx] <= mem_cmd.wdata;
            // Stores answer with zero
            rsp_data      <= '0;
         end else begin
            rsp_data <= mem[word_idx];
         end
      end
   end

   // Response valid
   // set on command, cleared when taken without a new one
   always_ff @(posedge clk) begin
      if (reset) begin
         rsp_valid <= 1'b0;
      end else if (cmd_xfer) begin
         rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
         rsp_valid <= 1'b0;
      end
   end

endmodule

// ==== hw/dmem_top.sv ====
// Data memory subsystem joining the data MMU and the data RAM
module dmem_top #(
   parameter int TLB_NSETS_LOG2 = 7,
   parameter int MEM_AW         = 10
) (
   input  logic                      clk,
   input  logic                      reset,
   // Command channel
   input  logic                      cmd_valid,
   output logic                      cmd_ready,
   input  dmmu_pkg::mem_cmd_t        cmd,
   input  dmmu_pkg::psr_t            psr,
   // Response channel
   output logic                      rsp_valid,
   input  logic                      rsp_ready,
   output logic [dmmu_pkg::dw-1:0]   rsp_data,
   // Exceptions
   output logic                      tlb_miss,
   output logic                      page_fault,
   // Status and TLB software ports
   output logic [dmmu_pkg::dw-1:0]   dmmid,
   input  logic [TLB_NSETS_LOG2-1:0] tlbl_idx,
   input  dmmu_pkg::tlb_lo_t         tlbl_wdata,
   input  logic                      tlbl_we,
   output dmmu_pkg::tlb_lo_t         tlbl_rdata,
   input  logic [TLB_NSETS_LOG2-1:0] tlbh_idx,
   input  dmmu_pkg::tlb_hi_t         tlbh_wdata,
   input  logic                      tlbh_we,
   output dmmu_pkg::tlb_hi_t         tlbh_rdata
);

   // Physical command between MMU and RAM
   logic               mem_cmd_valid;
   logic               mem_cmd_ready;
   dmmu_pkg::mem_cmd_t mem_cmd;

   dmmu #(
      .TLB_NSETS_LOG2 (TLB_NSETS_LOG2)
   ) dmmu_i (
      .clk           (clk),
      .reset         (reset),
      .cmd_valid     (cmd_valid),
      .cmd_ready     (cmd_ready),
      .cmd           (cmd),
      .psr           (psr),
      .mem_cmd_valid (mem_cmd_valid),
      .mem_cmd_ready (mem_cmd_ready),
      .mem_cmd       (mem_cmd),
      .tlb_miss      (tlb_miss),
      .page_fault    (page_fault),
      .dmmid         (dmmid),
      .tlbl_idx      (tlbl_idx),
      .tlbl_wdata    (tlbl_wdata),
      .tlbl_we       (tlbl_we),
      .tlbl_rdata    (tlbl_rdata),
      .tlbh_idx      (tlbh_idx),
      .tlbh_wdata    (tlbh_wdata),
      .tlbh_we       (tlbh_we),
      .tlbh_rdata    (tlbh_rdata)
   );

   // Stand-in for the data cache
   data_ram #(
      .MEM_AW (MEM_AW)
   ) data_ram_i (
      .clk           (clk),
      .reset         (reset),
      .mem_cmd_valid (mem_cmd_valid),
      .mem_cmd_ready (mem_cmd_ready),
      .mem_cmd       (mem_cmd),
      .rsp_valid     (rsp_valid),
      .rsp_ready     (rsp_ready),
      .rsp_data      (rsp_data)
   );

endmodule

// ==== dv/dmmu_asserts.sv ====
// Concurrent checks on the data MMU exception strobes and memory handshake
module dmmu_asserts (
   input logic clk,
   input logic reset,
   input logic accept,
   input logic mem_cmd_valid,
   input logic tlb_miss,
   input logic page_fault
);

   // One exception kind at a time
   assert property (@(posedge clk) disable iff (reset) !(tlb_miss && page_fault))
      else $error("tlb_miss and page_fault high together");

   // Cancelled command stays hidden from memory
   assert property (@(posedge clk) disable iff (reset)
      !(mem_cmd_valid && (tlb_miss || page_fault)))
      else $error("mem_cmd_valid high together with an exception strobe");

   // Strobe only in the cycle after an accepted command
   assert property (@(posedge clk) disable iff (reset)
      (tlb_miss || page_fault) |-> $past(accept))
      else $error("exception strobe without an accepted command one cycle earlier");

endmodule

bind dmmu dmmu_asserts dmmu_asserts_i (
   .clk           (clk),
   .reset         (reset),
   .accept        (accept),
   .mem_cmd_valid (mem_cmd_valid),
   .tlb_miss      (tlb_miss),
   .page_fault    (page_fault)
);

// ==== dv/tb_dmem.sv ====
// Testbench for the data memory subsystem with a table of TLB and access steps applied in a loop
module tb_dmem;

   // One table row
   typedef struct packed {
      logic [1:0]     kind;
      dmmu_pkg::psr_t psr;
      logic [31:0]    addr;
      // Store flag for accesses or valid bit for TLB steps
      logic           we;
      // Physical address for accesses or high TLB word for TLB steps
      logic [31:0]    pa;
      logic [1:0]     outcome;
   } step_t;

   localparam logic [1:0] k_tlbw = 2'd0, k_tlbr = 2'd1, k_acc = 2'd2, k_hold = 2'd3;
   localparam logic [1:0] o_none = 2'd0, o_rsp = 2'd1, o_miss = 2'd2, o_fault = 2'd3;

   logic               clk, reset;
   logic               cmd_valid, cmd_ready, rsp_valid, rsp_ready;
   logic               tlb_miss, page_fault, tlbl_we, tlbh_we;
   logic [31:0]        rsp_data, dmmid;
   logic [6:0]         tlbl_idx, tlbh_idx;
   dmmu_pkg::mem_cmd_t cmd;
   dmmu_pkg::psr_t     psr;
   dmmu_pkg::tlb_lo_t  tlbl_wdata, tlbl_rdata;
   dmmu_pkg::tlb_hi_t  tlbh_wdata, tlbh_rdata;

   step_t       steps[$];
   // Expected responses with the oldest first
   logic [31:0] exp_q[$];
   // Expected physical addresses at the data RAM with the oldest first
   logic [31:0] pa_q[$];
   // Reference copy of the 1024-word data RAM
   logic [31:0] model [1024];
   int          errors;
   int          cur_step;
   integer      seed;

   dmem_top dmem_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic step_t make_step(input logic [1:0] kind, input logic [1:0] psr_v,
                                       input logic [31:0] addr, input logic we,
                                       input logic [31:0] pa, input logic [1:0] outcome);
      return {kind, psr_v, addr, we, pa, outcome};
   endfunction

   // Low TLB word as the VPN tag over twelve zero bits and the valid flag
   function automatic logic [31:0] lo_word(input step_t s);
      return {s.addr[31:13], 12'h000, s.we};
   endfunction

   task automatic write_tlb(input step_t s);
      @(negedge clk);
      tlbl_idx   = s.addr[19:13];
      tlbh_idx   = s.addr[19:13];
      tlbl_wdata = lo_word(s);
      tlbh_wdata = s.pa;
      tlbl_we    = 1'b1;
      tlbh_we    = 1'b1;
      @(negedge clk);
      tlbl_we = 1'b0;
      tlbh_we = 1'b0;
   endtask

   // Readback shows the entry one edge after the index
   task automatic check_tlb(input step_t s);
      @(negedge clk);
      tlbl_idx = s.addr[19:13];
      tlbh_idx = s.addr[19:13];
      @(negedge clk);
      assert (tlbl_rdata == lo_word(s)) else begin
         $display("Mismatch step %0d tlbl_rdata exp %h got %h", cur_step, lo_word(s),
                  tlbl_rdata);
         errors++;
      end
      assert (tlbh_rdata == s.pa) else begin
         $display("Mismatch step %0d tlbh_rdata exp %h got %h", cur_step, s.pa, tlbh_rdata);
         errors++;
      end
   endtask

   task automatic send_cmd(input step_t s);
      logic [31:0] wdata;
      int          n;
      wdata = $random(seed);
      @(negedge clk);
      // Stores answer zero
      // Loads return the word last stored at the physical address
      if (s.outcome == o_rsp) begin
         exp_q.push_back(s.we ? 32'h0 : model[s.pa[11:2]]);
         pa_q.push_back(s.pa);
         if (s.we) model[s.pa[11:2]] = wdata;
      end
      // Held-ready rows stall the response channel
      if (s.kind == k_hold) rsp_ready = 1'b0;
      psr       = s.psr;
      cmd       = {s.addr, s.we, wdata};
      cmd_valid = 1'b1;
      for (n = 0; n < 20; n++) begin
         @(posedge clk);
         if (cmd_ready) break;
         // Back-pressure has reached the command side so the held responses may go
         @(negedge clk);
         rsp_ready = 1'b1;
      end
      assert (n < 20) else begin
         $display("Step %0d: command not accepted within 20 cycles", cur_step);
         errors++;
      end
      // Held-ready rows leave valid up for a back-to-back follower
      if (s.kind == k_acc) begin
         @(negedge clk);
         cmd_valid = 1'b0;
      end
   endtask

   task automatic drain_rsps();
      int n;
      for (n = 0; n < 20; n++) begin
         @(negedge clk);
         if (exp_q.size() == 0) break;
      end
      assert (n < 20) else begin
         $display("Step %0d: expected response missing after 20 cycles", cur_step);
         errors++;
         exp_q.delete();
         pa_q.delete();
      end
   endtask

   task automatic await_strobe(input step_t s);
      int n;
      for (n = 0; n < 20; n++) begin
         @(posedge clk);
         if (tlb_miss || page_fault) break;
      end
      assert (n < 20) else begin
         $display("Step %0d: no exception strobe within 20 cycles", cur_step);
         errors++;
      end
      assert (n == 20 || tlb_miss == (s.outcome == o_miss)) else begin
         $display("Mismatch step %0d tlb_miss exp %h got %h", cur_step,
                  (s.outcome == o_miss), tlb_miss);
         errors++;
      end
      assert (n == 20 || page_fault == (s.outcome == o_fault)) else begin
         $display("Mismatch step %0d page_fault exp %h got %h", cur_step,
                  (s.outcome == o_fault), page_fault);
         errors++;
      end
   endtask

   // Every physical command taken by the data RAM against the oldest expected address
   always @(posedge clk) begin
      if (dmem_top_i.mem_cmd_valid && dmem_top_i.mem_cmd_ready) begin
         assert (pa_q.size() > 0) else begin
            $display("Step %0d: command reached memory with none expected", cur_step);
            errors++;
         end
         if (pa_q.size() > 0) begin
            assert (dmem_top_i.mem_cmd.addr == pa_q[0]) else begin
               $display("Mismatch step %0d mem_cmd.addr exp %h got %h", cur_step, pa_q[0],
                        dmem_top_i.mem_cmd.addr);
               errors++;
            end
            pa_q.delete(0);
         end
      end
   end

   // Every taken response against the oldest expected word
   always @(posedge clk) begin
      if (rsp_valid && rsp_ready) begin
         assert (exp_q.size() > 0) else begin
            $display("Step %0d: response arrived with none expected", cur_step);
            errors++;
         end
         if (exp_q.size() > 0) begin
            assert (rsp_data == exp_q[0]) else begin
               $display("Mismatch step %0d rsp_data exp %h got %h", cur_step, exp_q[0], rsp_data);
               errors++;
            end
            exp_q.delete(0);
         end
      end
   end

   initial begin
      step_t s;
      int    errs_before;
      seed       = 32;
      errors     = 0;
      cur_step   = 0;
      reset      = 1'b1;
      cmd_valid  = 1'b0;
      cmd        = '0;
      psr        = '0;
      rsp_ready  = 1'b1;
      tlbl_idx   = '0;
      tlbh_idx   = '0;
      tlbl_wdata = '0;
      tlbh_wdata = '0;
      tlbl_we    = 1'b0;
      tlbh_we    = 1'b0;
      // psr is {dmme, rm}
      // Pass-through store and load
      steps.push_back(make_step(k_acc, 2'b00, 32'h0000_0040, 1'b1, 32'h0000_0040, o_rsp));
      steps.push_back(make_step(k_acc, 2'b00, 32'h0000_0040, 1'b0, 32'h0000_0040, o_rsp));
      // VPN 0x23 to PPN 1 with all permissions
      steps.push_back(make_step(k_tlbw, 2'b00, 32'h0004_6010, 1'b1, 32'h0000_2079, o_none));
      steps.push_back(make_step(k_tlbr, 2'b00, 32'h0004_6010, 1'b1, 32'h0000_2079, o_none));
      steps.push_back(make_step(k_acc, 2'b10, 32'h0004_6010, 1'b1, 32'h0000_2010, o_rsp));
      steps.push_back(make_step(k_acc, 2'b00, 32'h0000_2010, 1'b0, 32'h0000_2010, o_rsp));
      // Invalid entry on index 0x43 and then a foreign VPN on index 0x23
      steps.push_back(make_step(k_tlbw, 2'b00, 32'h0008_6010, 1'b0, 32'h0000_2079, o_none));
      steps.push_back(make_step(k_acc, 2'b10, 32'h0008_6010, 1'b1, 32'h0000_2010, o_miss));
      steps.push_back(make_step(k_acc, 2'b10, 32'h0014_6010, 1'b1, 32'h0000_2010, o_miss));
      steps.push_back(make_step(k_acc, 2'b00, 32'h0000_2010, 1'b0, 32'h0000_2010, o_rsp));
      // Root-only page on PPN 2
      steps.push_back(make_step(k_tlbw, 2'b00, 32'h0006_8020, 1'b1, 32'h0000_4061, o_none));
      steps.push_back(make_step(k_acc, 2'b11, 32'h0006_8020, 1'b1, 32'h0000_4020, o_rsp));
      steps.push_back(make_step(k_acc, 2'b10, 32'h0006_8020, 1'b1, 32'h0000_4020, o_fault));
      steps.push_back(make_step(k_acc, 2'b11, 32'h0006_8020, 1'b0, 32'h0000_4020, o_rsp));
      // User read-only page on PPN 3
      steps.push_back(make_step(k_tlbw, 2'b00, 32'h0008_A030, 1'b1, 32'h0000_6011, o_none));
      steps.push_back(make_step(k_acc, 2'b00, 32'h0000_6030, 1'b1, 32'h0000_6030, o_rsp));
      steps.push_back(make_step(k_acc, 2'b10, 32'h0008_A030, 1'b0, 32'h0000_6030, o_rsp));
      steps.push_back(make_step(k_acc, 2'b10, 32'h0008_A030, 1'b1, 32'h0000_6030, o_fault));
      // Two loads under back-pressure drained by a third
      steps.push_back(make_step(k_hold, 2'b00, 32'h0000_0040, 1'b0, 32'h0000_0040, o_rsp));
      steps.push_back(make_step(k_hold, 2'b00, 32'h0000_2010, 1'b0, 32'h0000_2010, o_rsp));
      steps.push_back(make_step(k_acc, 2'b00, 32'h0000_4020, 1'b0, 32'h0000_4020, o_rsp));
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      assert (dmmid == 32'd7) else begin
         $display("Mismatch dmmid exp %h got %h", 32'd7, dmmid);
         errors++;
      end
      $display("Id check %s", errors == 0 ? "ok" : "error");
      for (cur_step = 0; cur_step < steps.size(); cur_step++) begin
         s           = steps[cur_step];
         errs_before = errors;
         if (s.kind == k_tlbw) begin
            write_tlb(s);
         end else if (s.kind == k_tlbr) begin
            check_tlb(s);
         end else begin
            send_cmd(s);
            if (s.kind == k_acc && s.outcome == o_rsp) begin
               drain_rsps();
            end else if (s.kind == k_acc) begin
               await_strobe(s);
            end
         end
         $display("Step %0d %s", cur_step, errors == errs_before ? "ok" : "error");
      end
      $display("Steps %0d, errors %0d", steps.size(), errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
hw/dmmu_pkg.sv
hw/cmd_pipebuf.sv
hw/tlb_ram.sv
hw/dmmu.sv
hw/data_ram.sv
hw/dmem_top.sv
dv/dmmu_asserts.sv
dv/tb_dmem.sv

// ==== Makefile ====
TOP = tb_dmem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f

run: compile
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
